// ==== Makefile ====
# Verilator build and run of the dual-clock FIFO testbench
# Any variable below can be overridden on the make command line

VERILATOR       ?= verilator
TOP             ?= cdc_fifo_tb
FILE_LIST       ?= files.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_MSG        ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST OBJ_DIR VERILATOR_FLAGS PASS_MSG"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/cdc_fifo_assertions.sv ====
/*
 * Concurrent checks on the FIFO flags, bound into every cdc_fifo instance.
 * Push-side checks run on push_clk and pop-side checks on pop_clk.
 * Each check is off while its own side is in reset.
 */
`timescale 1ns/10ps
`include "cdc_fifo_cfg.svh"

module cdc_fifo_assertions
  import cdc_fifo_count_pkg::*;
(
  input logic   push_clk,
  input logic   pop_clk,
  input logic   push_reset,
  input logic   pop_reset,
  input logic   pop,
  input logic   full,
  input logic   empty,
  input count_t items,
  input count_t push_items,
  input logic   wr_en
);

  localparam count_t depth_count = count_t'(`CDC_FIFO_DEPTH);

  // Push side may see stale pop counts but never more than depth words
  push_occupancy_in_range: assert property (
    @(posedge push_clk) disable iff (push_reset) push_items <= depth_count
  ) else $error("push-side occupancy %0d is above depth", push_items);

  // A returning pop count only frees entries, so only a local write can fill the FIFO
  full_rises_on_write: assert property (
    @(posedge push_clk) disable iff (push_reset) $rose(full) |-> $past(wr_en)
  ) else $error("full rose without a write on the previous push_clk edge");

  items_within_depth: assert property (
    @(posedge pop_clk) disable iff (pop_reset) items <= depth_count
  ) else $error("items %0d is above depth", items);

  // An arriving push count only adds words, so only a local pop can empty the FIFO
  empty_rises_on_pop: assert property (
    @(posedge pop_clk) disable iff (pop_reset) $rose(empty) |-> $past(pop)
  ) else $error("empty rose without a pop on the previous pop_clk edge");

  // A dropped push must never reach the memory
  no_write_while_full: assert property (
    @(posedge push_clk) disable iff (push_reset) !(wr_en && full)
  ) else $error("memory write enabled while full");

endmodule

bind cdc_fifo cdc_fifo_assertions assertions_i (
  .push_clk   (push_clk),
  .pop_clk    (pop_clk),
  .push_reset (push_reset),
  .pop_reset  (pop_reset),
  .pop        (pop),
  .full       (full),
  .empty      (empty),
  .items      (items),
  .push_items (push_status.items),
  .wr_en      (wr_port.en)
);

// ==== dv/cdc_fifo_tb.sv ====
/*
 * Directed testbench of the dual-clock FIFO against a queue of accepted words.
 * Both clocks have a 40 ns period and pop_clk lags by 13 ns so edges never align.
 */
`timescale 1ns/10ps
`include "cdc_fifo_cfg.svh"

module cdc_fifo_tb
  import cdc_fifo_count_pkg::*;
  import cdc_fifo_data_pkg::*;
();

  localparam int depth         = `CDC_FIFO_DEPTH;
  // Pop clocks from an accepted push until empty must have fallen
  localparam int latency_limit = `CDC_FIFO_SYNC_STAGES + 4;
  localparam int drain_limit   = 4 * latency_limit;

  logic   push_clk;
  logic   pop_clk;
  logic   push_reset;
  logic   pop_reset;
  logic   push;
  data_t  push_data;
  logic   pop;
  logic   full;
  data_t  pop_data;
  logic   empty;
  count_t items;

  // Words accepted by the push side and not yet popped in push order
  data_t model_q [$];
  int    error_count;
  int    tests_run;
  int    tests_failed;
  int    errors_at_start;
  bit    push_done;

  cdc_fifo dut_i (
    .push_clk   (push_clk),
    .pop_clk    (pop_clk),
    .push_reset (push_reset),
    .pop_reset  (pop_reset),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .full       (full),
    .pop_data   (pop_data),
    .empty      (empty),
    .items      (items)
  );

  initial begin
    push_clk = 1'b0;
    forever #20 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    #13;
    forever #20 pop_clk = ~pop_clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    error_count++;
  endtask

  // Inputs of each side change 2 ns after that side's rising edge
  task automatic push_step();
    @(posedge push_clk);
    #2;
  endtask

  task automatic pop_step();
    @(posedge pop_clk);
    #2;
  endtask

  task automatic apply_reset();
    fork
      begin
        push_step();
        push_reset = 1'b1;
        push = 1'b0;
        repeat (3) @(posedge push_clk);
        #2;
        push_reset = 1'b0;
      end
      begin
        pop_step();
        pop_reset = 1'b1;
        pop = 1'b0;
        repeat (3) @(posedge pop_clk);
        #2;
        pop_reset = 1'b0;
      end
    join
    model_q.delete();
  endtask

  // Called 2 ns after a push_clk edge, a push is taken at the next edge unless full
  task automatic push_word(input data_t word, output bit accepted);
    push      = 1'b1;
    push_data = word;
    accepted  = !full;
    if (accepted) begin
      model_q.push_back(word);
    end
    push_step();
    push = 1'b0;
  endtask

  // Called 2 ns after a pop_clk edge with empty low, the head must match the model
  task automatic pop_and_check();
    assert (model_q.size() != 0) else
      report_failure("FIFO shows a word that was never pushed");
    if (model_q.size() != 0) begin
      check_value("pop_data", 32'(pop_data), 32'(model_q.pop_front()));
    end
    pop = 1'b1;
    pop_step();
    pop = 1'b0;
  endtask

  task automatic wait_for_items(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (int'(items) < target && cycles < limit) begin
      pop_step();
      cycles++;
    end
    assert (int'(items) >= target) else
      report_failure($sformatf("items did not reach %0d within %0d pop_clk cycles",
                               target, limit));
  endtask

  // Returned pop counts have to reach the push side before full means anything
  task automatic wait_push_drained(input int limit);
    int cycles;
    cycles = 0;
    push_step();
    while (dut_i.push_status.items != '0 && cycles < limit) begin
      push_step();
      cycles++;
    end
    assert (dut_i.push_status.items == '0) else
      report_failure("push side still counts words after the pop side drained");
  endtask

  task automatic begin_test();
    errors_at_start = error_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count != errors_at_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_at_start);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic verify_reset_state();
    pop_step();
    check_value("empty", 32'(empty), 32'd1);
    check_value("items", 32'(items), 32'd0);
    push_step();
    check_value("full", 32'(full), 32'd0);
    check_value("wr_port.en", 32'(dut_i.wr_port.en), 32'd0);
  endtask

  // One word crosses, is read at the head, and its pop empties the FIFO again
  task automatic single_word_roundtrip();
    bit accepted;
    push_step();
    push_word(data_t'($urandom), accepted);
    assert (accepted) else report_failure("push into an empty FIFO was refused");
    pop_step();
    wait_for_items(1, latency_limit);
    check_value("empty", 32'(empty), 32'd0);
    if (!empty) begin
      pop_and_check();
      check_value("empty", 32'(empty), 32'd1);
    end
  endtask

  task automatic fill_until_full();
    bit accepted;
    wait_push_drained(drain_limit);
    for (int i = 0; i < depth; i++) begin
      push_word(data_t'($urandom), accepted);
      assert (accepted) else report_failure($sformatf("push %0d refused before full", i));
    end
    check_value("full", 32'(full), 32'd1);
    // This word must be dropped
    push_word(data_t'($urandom), accepted);
    assert (!accepted) else report_failure("push while full was accepted");
    check_value("model size", 32'(model_q.size()), 32'(depth));
    pop_step();
    wait_for_items(depth, latency_limit);
    for (int i = 0; i < depth; i++) begin
      assert (!empty) else report_failure($sformatf("empty after only %0d pops", i));
      pop_and_check();
    end
    check_value("empty", 32'(empty), 32'd1);
    check_value("items", 32'(items), 32'd0);
    // A dropped word showing up late would raise items here
    repeat (latency_limit) begin
      pop_step();
      check_value("items", 32'(items), 32'd0);
    end
  endtask

  task automatic pop_on_empty();
    pop_step();
    check_value("empty", 32'(empty), 32'd1);
    pop = 1'b1;
    repeat (3) pop_step();
    pop = 1'b0;
    check_value("empty", 32'(empty), 32'd1);
    check_value("items", 32'(items), 32'd0);
    // The head must not have moved, so the next word still comes out right
    single_word_roundtrip();
  endtask

  task automatic random_interleave();
    bit accepted;
    int pop_cycles;
    wait_push_drained(drain_limit);
    push_done = 1'b0;
    fork
      begin
        push_step();
        for (int i = 0; i < 200; i++) begin
          // Push side may see the FIFO fuller than it is but never emptier
          assert (full || model_q.size() < depth) else
            report_failure("full is low while the FIFO holds depth words");
          if ($urandom_range(99, 0) < 60) begin
            push_word(data_t'($urandom), accepted);
          end else begin
            push_step();
          end
        end
        push_done = 1'b1;
      end
      begin
        pop_step();
        pop_cycles = 0;
        while (!(push_done && model_q.size() == 0) && pop_cycles < 2000) begin
          assert (int'(items) <= depth) else
            report_failure($sformatf("items %0d exceeds depth", items));
          if (!empty && $urandom_range(99, 0) < 50) begin
            pop_and_check();
          end else begin
            pop_step();
          end
          pop_cycles++;
        end
        assert (model_q.size() == 0) else
          report_failure("random traffic did not drain within 2000 pop_clk cycles");
      end
    join
    check_value("empty", 32'(empty), 32'd1);
  endtask

  task automatic reset_mid_stream();
    bit accepted;
    push_step();
    repeat (3) push_word(data_t'($urandom), accepted);
    // Words are still crossing when both sides go into reset
    apply_reset();
    verify_reset_state();
    single_word_roundtrip();
  endtask

  initial begin
    push_reset   = 1'b1;
    pop_reset    = 1'b1;
    push         = 1'b0;
    push_data    = '0;
    pop          = 1'b0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    push_done    = 1'b0;
    void'($urandom(90164));

    begin_test();
    apply_reset();
    verify_reset_state();
    end_test("reset state");

    begin_test();
    single_word_roundtrip();
    end_test("single word");

    begin_test();
    fill_until_full();
    end_test("fill and drop");

    begin_test();
    pop_on_empty();
    end_test("pop on empty");

    begin_test();
    random_interleave();
    end_test("random traffic");

    begin_test();
    reset_mid_stream();
    end_test("reset mid-stream");

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
hdl/cdc_fifo_count_pkg.sv
hdl/cdc_fifo_data_pkg.sv
hdl/cdc_sync.sv
hdl/cdc_fifo_push_flag_mgr.sv
hdl/cdc_fifo_pop_flag_mgr.sv
hdl/cdc_fifo_ram.sv
hdl/cdc_fifo.sv
dv/cdc_fifo_assertions.sv
dv/cdc_fifo_tb.sv

// ==== hdl/cdc_fifo.sv ====
/*
 * Dual-clock FIFO top, push side on push_clk and pop side on pop_clk.
 * Strobe interface: push while full and pop while empty are ignored.
 * pop_data is the head word and is meaningful only while empty is low.
 */
`timescale 1ns/10ps
`include "cdc_fifo_cfg.svh"

module cdc_fifo
  import cdc_fifo_count_pkg::*;
  import cdc_fifo_data_pkg::*;
(
  input  logic   push_clk,
  input  logic   pop_clk,
  input  logic   push_reset,
  input  logic   pop_reset,
  input  logic   push,
  input  data_t  push_data,
  input  logic   pop,
  output logic   full,
  output data_t  pop_data,
  output logic   empty,
  output count_t items
);

  wr_port_t              wr_port;
  logic [addr_width-1:0] rd_addr;
  status_t               push_status;
  status_t               pop_status;
  // Counts and reset flags before and after their crossing
  count_t                push_count_gray;
  count_t                push_count_gray_sync;
  count_t                pop_count_gray;
  count_t                pop_count_gray_sync;
  logic                  reset_active_push;
  logic                  reset_active_push_sync;
  logic                  reset_active_pop;
  logic                  reset_active_pop_sync;

  cdc_fifo_push_flag_mgr push_mgr_i (
    .clk               (push_clk),
    .reset             (push_reset),
    .push              (push),
    .push_data         (push_data),
    .pop_count_gray    (pop_count_gray_sync),
    .reset_active_pop  (reset_active_pop_sync),
    .wr_port           (wr_port),
    .push_count_gray   (push_count_gray),
    .push_status       (push_status),
    .reset_active_push (reset_active_push)
  );

  // Push domain to pop domain
  cdc_sync #(.payload_t(count_t), .stages(`CDC_FIFO_SYNC_STAGES)) push_count_sync_i (
    .clk   (pop_clk),
    .reset (pop_reset),
    .d     (push_count_gray),
    .q     (push_count_gray_sync)
  );

  cdc_sync #(.payload_t(logic), .stages(`CDC_FIFO_SYNC_STAGES)) push_reset_sync_i (
    .clk   (pop_clk),
    .reset (pop_reset),
    .d     (reset_active_push),
    .q     (reset_active_push_sync)
  );

  // Pop domain back to push domain
  cdc_sync #(.payload_t(count_t), .stages(`CDC_FIFO_SYNC_STAGES)) pop_count_sync_i (
    .clk   (push_clk),
    .reset (push_reset),
    .d     (pop_count_gray),
    .q     (pop_count_gray_sync)
  );

  cdc_sync #(.payload_t(logic), .stages(`CDC_FIFO_SYNC_STAGES)) pop_reset_sync_i (
    .clk   (push_clk),
    .reset (push_reset),
    .d     (reset_active_pop),
    .q     (reset_active_pop_sync)
  );

  cdc_fifo_pop_flag_mgr pop_mgr_i (
    .clk               (pop_clk),
    .reset             (pop_reset),
    .pop               (pop),
    .push_count_gray   (push_count_gray_sync),
    .reset_active_push (reset_active_push_sync),
    .pop_count_gray    (pop_count_gray),
    .rd_addr           (rd_addr),
    .pop_status        (pop_status),
    .reset_active_pop  (reset_active_pop)
  );

  cdc_fifo_ram ram_i (
    .wr_clk  (push_clk),
    .wr_port (wr_port),
    .rd_addr (rd_addr),
    .rd_data (pop_data)
  );

  // Status fields out to the user ports
  assign full  = push_status.flag;
  assign empty = pop_status.flag;
  assign items = pop_status.items;

endmodule

// ==== hdl/cdc_fifo_count_pkg.sv ====
/*
 * Count types shared by both flag managers of the FIFO.
 * Counts run modulo 2**count_width, so depth has to be a power of two.
 */
`include "cdc_fifo_cfg.svh"

package cdc_fifo_count_pkg;

  // One extra bit over the address tells a full FIFO from an empty one
  localparam int count_width = $clog2(`CDC_FIFO_DEPTH + 1);
  // Memory address is the count modulo depth
  localparam int addr_width = (count_width > 1) ? count_width - 1 : 1;

  // Same vector holds a binary count or its Gray form
  typedef logic [count_width-1:0] count_t;

  // Occupancy seen from one side, flag is full on push and empty on pop
  typedef struct packed {
    count_t items;
    logic   flag;
  } status_t;

  // Only one bit changes per increment, which is what makes the crossing safe
  function automatic count_t bin2gray(count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic count_t gray2bin(count_t gray);
    count_t bin;
    bin[count_width-1] = gray[count_width-1];
    // Each binary bit is the XOR of all Gray bits at and above it
    for (int i = count_width - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== hdl/cdc_fifo_data_pkg.sv ====
/*
 * Payload types of the FIFO and the write port of its memory.
 * Address width follows the count package, so that one compiles first.
 */
`include "cdc_fifo_cfg.svh"

package cdc_fifo_data_pkg;

  import cdc_fifo_count_pkg::*;

  // One stored word
  typedef logic [`CDC_FIFO_DATA_WIDTH-1:0] data_t;

  // Everything the push side hands the memory in one push_clk cycle
  typedef struct packed {
    logic                  en;
    logic [addr_width-1:0] addr;
    data_t                 data;
  } wr_port_t;

endpackage

// ==== hdl/cdc_fifo_pop_flag_mgr.sv ====
/*
 * Pop-side bookkeeping of the dual-clock FIFO: local count, items, empty, head.
 * push_count_gray and reset_active_push must already be synchronized to clk.
 * A pop while empty is ignored, and the head word is valid only while not empty.
 */
`timescale 1ns/10ps
`include "cdc_fifo_cfg.svh"

module cdc_fifo_pop_flag_mgr
  import cdc_fifo_count_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pop,
  input  count_t                push_count_gray,
  input  logic                  reset_active_push,
  output count_t                pop_count_gray,
  output logic [addr_width-1:0] rd_addr,
  output status_t               pop_status,
  output logic                  reset_active_pop
);

  // Count trails the reset flag by one cycle on its way out
  localparam int count_delay = `CDC_FIFO_REG_RESET_ACTIVE + 1;

  logic   pop_accept;
  logic   empty;
  count_t pop_count;
  count_t pop_count_next;
  count_t push_count;
  count_t push_count_saved;
  count_t push_count_visible;
  count_t items;
  count_t gray_stages [count_delay];

  // A pop on an empty FIFO does nothing
  assign pop_accept     = pop && !empty;
  assign pop_count_next = pop_count + count_t'(pop_accept);

  always_ff @(posedge clk) begin
    if (reset) begin
      pop_count <= '0;
    end else begin
      pop_count <= pop_count_next;
    end
  end

  // Head of the queue, the memory reads it without a clock
  assign rd_addr = pop_count[addr_width-1:0];

  // Registered Gray count for the push side, so no glitch crosses
  always_ff @(posedge clk) begin
    if (reset) begin
      gray_stages <= '{default: '0};
    end else begin
      gray_stages[0] <= bin2gray(pop_count_next);
      for (int i = 1; i < count_delay; i++) begin
        gray_stages[i] <= gray_stages[i-1];
      end
    end
  end

  assign pop_count_gray = gray_stages[count_delay-1];

  generate
    if (`CDC_FIFO_REG_RESET_ACTIVE != 0) begin : g_reset_flop
      // Flopped copy of reset keeps the crossing flag glitch free
      always_ff @(posedge clk) begin
        reset_active_pop <= reset;
      end
    end else begin : g_reset_direct
      assign reset_active_pop = reset;
    end
  endgenerate

  assign push_count = gray2bin(push_count_gray);

  // Hold the remote count while the push side is in reset so it never reads as zero
  always_ff @(posedge clk) begin
    if (reset) begin
      push_count_saved <= '0;
    end else if (!reset_active_push) begin
      push_count_saved <= push_count;
    end
  end

  assign push_count_visible = reset_active_push ? push_count_saved : push_count;

  // Wraps modulo 2**count_width like the counters themselves
  assign items = push_count_visible - pop_count;
  assign empty = (items == '0);

  assign pop_status.items = items;
  assign pop_status.flag  = empty;

endmodule

// ==== hdl/cdc_fifo_push_flag_mgr.sv ====
/*
 * Push-side bookkeeping of the dual-clock FIFO: local count, full, write port.
 * pop_count_gray and reset_active_pop must already be synchronized to clk.
 * A push while full is dropped without any indication to the user.
 */
`timescale 1ns/10ps
`include "cdc_fifo_cfg.svh"

module cdc_fifo_push_flag_mgr
  import cdc_fifo_count_pkg::*;
  import cdc_fifo_data_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  data_t    push_data,
  input  count_t   pop_count_gray,
  input  logic     reset_active_pop,
  output wr_port_t wr_port,
  output count_t   push_count_gray,
  output status_t  push_status,
  output logic     reset_active_push
);

  // The far side has to see our reset before it sees the cleared count
  localparam int     count_delay = `CDC_FIFO_REG_RESET_ACTIVE + 1;
  localparam count_t depth_count = count_t'(`CDC_FIFO_DEPTH);

  logic   push_accept;
  logic   full;
  count_t push_count;
  count_t push_count_next;
  count_t pop_count;
  count_t pop_count_saved;
  count_t pop_count_visible;
  count_t items;
  count_t gray_stages [count_delay];

  // Only a push that finds room takes effect
  assign push_accept     = push && !full;
  assign push_count_next = push_count + count_t'(push_accept);

  always_ff @(posedge clk) begin
    if (reset) begin
      push_count <= '0;
    end else begin
      push_count <= push_count_next;
    end
  end

  // The word goes into memory on the same edge that counts the push
  assign wr_port.en   = push_accept;
  assign wr_port.addr = push_count[addr_width-1:0];
  assign wr_port.data = push_data;

  // Outgoing count is Gray coded from a flop, never from logic
  always_ff @(posedge clk) begin
    if (reset) begin
      gray_stages <= '{default: '0};
    end else begin
      gray_stages[0] <= bin2gray(push_count_next);
      for (int i = 1; i < count_delay; i++) begin
        gray_stages[i] <= gray_stages[i-1];
      end
    end
  end

  assign push_count_gray = gray_stages[count_delay-1];

  // Reset flag leads the count by exactly one cycle
  generate
    if (`CDC_FIFO_REG_RESET_ACTIVE != 0) begin : g_reset_flop
      always_ff @(posedge clk) begin
        reset_active_push <= reset;
      end
    end else begin : g_reset_direct
      assign reset_active_push = reset;
    end
  endgenerate

  assign pop_count = gray2bin(pop_count_gray);

  // While the pop side is in reset its count is meaningless, so keep the last good one
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_count_saved <= '0;
    end else if (!reset_active_pop) begin
      pop_count_saved <= pop_count;
    end
  end

  assign pop_count_visible = reset_active_pop ? pop_count_saved : pop_count;

  // Modular difference stays correct across counter wrap
  assign items = push_count - pop_count_visible;
  assign full  = (items == depth_count);

  assign push_status.items = items;
  assign push_status.flag  = full;

endmodule

// ==== hdl/cdc_fifo_ram.sv ====
/*
 * Register-file storage of the FIFO, written on wr_clk and read without a clock.
 * Contents are not reset, and words past the head are only stale data.
 * Depth must equal 2**addr_width so every address maps to an entry.
 */
`timescale 1ns/10ps
`include "cdc_fifo_cfg.svh"

module cdc_fifo_ram
  import cdc_fifo_count_pkg::*;
  import cdc_fifo_data_pkg::*;
(
  input  logic                  wr_clk,
  input  wr_port_t              wr_port,
  input  logic [addr_width-1:0] rd_addr,
  output data_t                 rd_data
);

  // One word per FIFO entry
  data_t mem [`CDC_FIFO_DEPTH];

  // Single writer from the push domain
  always_ff @(posedge wr_clk) begin
    if (wr_port.en) begin
      mem[wr_port.addr] <= wr_port.data;
    end
  end

  // The pop side only reads an entry once the flags say it was written,
  // by then the word has been stable for several pop clocks
  assign rd_data = mem[rd_addr];

endmodule

// ==== hdl/cdc_sync.sv ====
/*
 * Plain flop chain for crossing into the clock domain of clk.
 * Safe only for single-bit levels or Gray-coded values, never raw binary.
 * The stages parameter has to be at least 1.
 */
`timescale 1ns/10ps

module cdc_sync #(
  parameter type payload_t = logic,
  parameter int  stages    = 2
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t d,
  output payload_t q
);

  // First entry samples the foreign domain and may go metastable
  payload_t chain [stages];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < stages; i++) begin
        chain[i] <= '0;
      end
    end else begin
      chain[0] <= d;
      // Later entries give a metastable value time to settle
      for (int i = 1; i < stages; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  // Only the last flop is safe to read in this domain
  assign q = chain[stages-1];

endmodule

// ==== include/cdc_fifo_cfg.svh ====
/*
 * Build-time configuration of the dual-clock FIFO, shared by packages and RTL.
 * CDC_FIFO_DEPTH must be a power of two and at least 2.
 * CDC_FIFO_SYNC_STAGES must be at least 1, and 2 or more on real silicon.
 */
`ifndef CDC_FIFO_CFG_SVH
`define CDC_FIFO_CFG_SVH

// Number of storage entries
`define CDC_FIFO_DEPTH 8

// Width of one payload word in bits
`define CDC_FIFO_DATA_WIDTH 16

// Flops in each clock-crossing synchronizer
`define CDC_FIFO_SYNC_STAGES 2

// 1 puts a flop on the outgoing reset flag, 0 sends reset straight across
`define CDC_FIFO_REG_RESET_ACTIVE 1

`endif
